//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  ex_pkg::word_t   a,
    input  ex_pkg::word_t   b,
    input  ex_pkg::alu_op_t alu_op,
    output ex_pkg::word_t   result,
    output logic            overflow
);

    ex_pkg::word_t sum;
    ex_pkg::word_t diff;
    logic          less_signed;
    logic          less_unsigned;
    logic          add_of;
    logic          sub_of;

    assign sum  = a + b;
    assign diff = a - b;

    // Compares for slt and sltu
    assign less_signed   = $signed(a) < $signed(b);
    assign less_unsigned = a < b;

    // Signed overflow when equal-sign operands give a result of the other sign
    assign add_of = (a[ex_pkg::data_width-1] == b[ex_pkg::data_width-1]) &&
                    (sum[ex_pkg::data_width-1] != a[ex_pkg::data_width-1]);

    // Subtract flips the sign of b
    assign sub_of = (a[ex_pkg::data_width-1] != b[ex_pkg::data_width-1]) &&
                    (diff[ex_pkg::data_width-1] != a[ex_pkg::data_width-1]);

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (alu_op)
            ex_pkg::alu_add: begin
                result   = sum;
                overflow = add_of;
            end
            ex_pkg::alu_addu: result = sum;
            ex_pkg::alu_sub: begin
                result   = diff;
                overflow = sub_of;
            end
            ex_pkg::alu_subu: result = diff;
            ex_pkg::alu_and:  result = a & b;
            ex_pkg::alu_or:   result = a | b;
            ex_pkg::alu_xor:  result = a ^ b;
            ex_pkg::alu_nor:  result = ~(a | b);
            // Less-than gives 1 or 0 in a full word
            ex_pkg::alu_slt:  result = ex_pkg::word_t'(less_signed);
            ex_pkg::alu_sltu: result = ex_pkg::word_t'(less_unsigned);
            // Immediate into the upper half
            ex_pkg::alu_lui:  result = b << 16;
            default:          result = '0;
        endcase
    end

endmodule

//--- hw/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter (
    input  ex_pkg::word_t     shift_in,
    input  ex_pkg::shamt_t    shift_amount,
    input  ex_pkg::shift_op_t shift_op,
    output ex_pkg::word_t     shift_out
);

    // stage[i] holds the word after the first i amount bits
    ex_pkg::word_t stage [6];

    assign stage[0] = shift_in;

    //////////////////////////////////////////////////////////////////////
    // Five stages of 1, 2, 4, 8 and 16 positions
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < 5; i++) begin : g_stage
        ex_pkg::word_t shifted;

        always_comb begin
            case (shift_op)
                ex_pkg::shift_sll: shifted = stage[i] << (1 << i);
                ex_pkg::shift_srl: shifted = stage[i] >> (1 << i);
                // Sign bit fills from the left
                ex_pkg::shift_sra: begin
                    shifted = ex_pkg::word_t'($signed(stage[i]) >>> (1 << i));
                end
                default: shifted = stage[i];
            endcase
        end

        // Bit i of the amount enables this stage
        assign stage[i+1] = shift_amount[i] ? shifted : stage[i];
    end

    assign shift_out = stage[5];

endmodule

//--- hw/ex_pipeline.sv
`timescale 1ns/1ps

module ex_pipeline (
    input  logic               ui_clk_from_ddr,
    input  logic               reset,
    input  logic               ex_valid,
    input  ex_pkg::alu_op_t    alu_op,
    input  ex_pkg::shift_op_t  shift_op,
    input  ex_pkg::exres_sel_t exres_sel,
    input  logic               b_imm_sel,
    input  logic               shamt_sel,
    input  ex_pkg::shamt_t     shamt,
    input  ex_pkg::word_t      imm,
    input  ex_pkg::reg_addr_t  rs_addr,
    input  ex_pkg::reg_addr_t  rt_addr,
    input  ex_pkg::word_t      rs_data,
    input  ex_pkg::word_t      rt_data,
    input  ex_pkg::reg_addr_t  rd_addr,
    input  logic               reg_w,
    input  logic               of_trap,
    output logic               wb_valid,
    output logic               wb_reg_w,
    output logic               wb_overflow,
    output ex_pkg::reg_addr_t  wb_rd_addr,
    output ex_pkg::word_t      wb_data
);

    // Operands after forwarding
    ex_pkg::word_t     operand_a;
    ex_pkg::word_t     alu_b;
    ex_pkg::word_t     shift_in;
    ex_pkg::shamt_t    shift_amount;

    ex_pkg::word_t     alu_result;
    logic              alu_overflow;
    ex_pkg::word_t     shift_result;

    // MEM stage, fed back for forwarding
    ex_pkg::reg_addr_t mem_rd_addr;
    logic              mem_reg_w;
    ex_pkg::word_t     mem_data;

    operand_select u_operand_select (
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .imm          (imm),
        .b_imm_sel    (b_imm_sel),
        .shamt_sel    (shamt_sel),
        .shamt        (shamt),
        .mem_rd_addr  (mem_rd_addr),
        .mem_reg_w    (mem_reg_w),
        .mem_data     (mem_data),
        .wb_rd_addr   (wb_rd_addr),
        .wb_reg_w     (wb_reg_w),
        .wb_data      (wb_data),
        .operand_a    (operand_a),
        .alu_b        (alu_b),
        .shift_in     (shift_in),
        .shift_amount (shift_amount)
    );

    alu u_alu (
        .a        (operand_a),
        .b        (alu_b),
        .alu_op   (alu_op),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    barrel_shifter u_barrel_shifter (
        .shift_in     (shift_in),
        .shift_amount (shift_amount),
        .shift_op     (shift_op),
        .shift_out    (shift_result)
    );

    result_pipe u_result_pipe (
        .ui_clk_from_ddr (ui_clk_from_ddr),
        .reset           (reset),
        .ex_valid        (ex_valid),
        .exres_sel       (exres_sel),
        .alu_result      (alu_result),
        .shift_result    (shift_result),
        .operand_a       (operand_a),
        .alu_overflow    (alu_overflow),
        .rd_addr         (rd_addr),
        .reg_w           (reg_w),
        .of_trap         (of_trap),
        .mem_rd_addr     (mem_rd_addr),
        .mem_reg_w       (mem_reg_w),
        .mem_data        (mem_data),
        .wb_valid        (wb_valid),
        .wb_reg_w        (wb_reg_w),
        .wb_overflow     (wb_overflow),
        .wb_rd_addr      (wb_rd_addr),
        .wb_data         (wb_data)
    );

endmodule

//--- hw/ex_pkg.sv
package ex_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int data_width = 32;

    typedef logic [data_width-1:0] word_t;

    // Register 0 reads as zero and is never forwarded
    typedef logic [4:0] reg_addr_t;

    typedef logic [4:0] shamt_t;

    //////////////////////////////////////////////////////////////////////
    // Operation codes
    //////////////////////////////////////////////////////////////////////

    // Only add and sub can flag signed overflow
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_addu = 4'd1,
        alu_sub  = 4'd2,
        alu_subu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_lui  = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        shift_sll = 2'd0,
        shift_srl = 2'd1,
        shift_sra = 2'd2
    } shift_op_t;

    // Source of the execute result
    typedef enum logic [1:0] {
        res_alu    = 2'd0,
        res_shift  = 2'd1,
        res_pass_a = 2'd2
    } exres_sel_t;

endpackage

//--- hw/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  ex_pkg::reg_addr_t rs_addr,
    input  ex_pkg::reg_addr_t rt_addr,
    input  ex_pkg::word_t     rs_data,
    input  ex_pkg::word_t     rt_data,
    input  ex_pkg::word_t     imm,
    input  logic              b_imm_sel,
    input  logic              shamt_sel,
    input  ex_pkg::shamt_t    shamt,
    input  ex_pkg::reg_addr_t mem_rd_addr,
    input  logic              mem_reg_w,
    input  ex_pkg::word_t     mem_data,
    input  ex_pkg::reg_addr_t wb_rd_addr,
    input  logic              wb_reg_w,
    input  ex_pkg::word_t     wb_data,
    output ex_pkg::word_t     operand_a,
    output ex_pkg::word_t     alu_b,
    output ex_pkg::word_t     shift_in,
    output ex_pkg::shamt_t    shift_amount
);

    ex_pkg::word_t fwd_a;
    ex_pkg::word_t fwd_b;

    // MEM stage first, then WB, then the register value
    function automatic ex_pkg::word_t forward(
        input ex_pkg::reg_addr_t src,
        input ex_pkg::word_t     reg_data
    );
        if (src != '0 && mem_reg_w && src == mem_rd_addr) begin
            return mem_data;
        end else if (src != '0 && wb_reg_w && src == wb_rd_addr) begin
            return wb_data;
        end
        return reg_data;
    endfunction

    always_comb begin
        fwd_a = forward(rs_addr, rs_data);
        fwd_b = forward(rt_addr, rt_data);
    end

    assign operand_a = fwd_a;
    assign shift_in  = fwd_b;

    // Immediate replaces B for the ALU only
    assign alu_b = b_imm_sel ? imm : fwd_b;

    // Variable shifts take the amount from rs
    assign shift_amount = shamt_sel ? fwd_a[4:0] : shamt;

endmodule

//--- hw/result_pipe.sv
`timescale 1ns/1ps

module result_pipe (
    input  logic               ui_clk_from_ddr,
    input  logic               reset,
    input  logic               ex_valid,
    input  ex_pkg::exres_sel_t exres_sel,
    input  ex_pkg::word_t      alu_result,
    input  ex_pkg::word_t      shift_result,
    input  ex_pkg::word_t      operand_a,
    input  logic               alu_overflow,
    input  ex_pkg::reg_addr_t  rd_addr,
    input  logic               reg_w,
    input  logic               of_trap,
    output ex_pkg::reg_addr_t  mem_rd_addr,
    output logic               mem_reg_w,
    output ex_pkg::word_t      mem_data,
    output logic               wb_valid,
    output logic               wb_reg_w,
    output logic               wb_overflow,
    output ex_pkg::reg_addr_t  wb_rd_addr,
    output ex_pkg::word_t      wb_data
);

    ex_pkg::word_t ex_result;
    logic          ex_overflow;
    logic          ex_reg_w;
    logic          mem_valid;
    logic          mem_overflow;

    //////////////////////////////////////////////////////////////////////
    // EX result and write enable
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (exres_sel)
            ex_pkg::res_alu:    ex_result = alu_result;
            ex_pkg::res_shift:  ex_result = shift_result;
            ex_pkg::res_pass_a: ex_result = operand_a;
            default:            ex_result = alu_result;
        endcase
    end

    // Overflow counts only when the ALU result is the one taken
    assign ex_overflow = ex_valid && (exres_sel == ex_pkg::res_alu) && alu_overflow;

    // A trapping overflow kills the register write
    assign ex_reg_w = ex_valid && reg_w && !(of_trap && ex_overflow);

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            mem_valid    <= 1'b0;
            mem_reg_w    <= 1'b0;
            mem_overflow <= 1'b0;
            mem_rd_addr  <= '0;
            mem_data     <= '0;
        end else begin
            mem_valid    <= ex_valid;
            mem_reg_w    <= ex_reg_w;
            mem_overflow <= ex_overflow;
            // Payload holds between strobes
            if (ex_valid) begin
                mem_rd_addr <= rd_addr;
                mem_data    <= ex_result;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // MEM/WB register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            wb_valid    <= 1'b0;
            wb_reg_w    <= 1'b0;
            wb_overflow <= 1'b0;
            wb_rd_addr  <= '0;
            wb_data     <= '0;
        end else begin
            wb_valid    <= mem_valid;
            wb_reg_w    <= mem_reg_w;
            wb_overflow <= mem_overflow;
            wb_rd_addr  <= mem_rd_addr;
            wb_data     <= mem_data;
        end
    end

endmodule

//--- project.f
hw/ex_pkg.sv
hw/alu.sv
hw/barrel_shifter.sv
hw/operand_select.sv
hw/result_pipe.sv
hw/ex_pipeline.sv
sim/tb_clock.sv
sim/result_pipe_sva.sv
sim/ex_pipeline_tb.sv

//--- sim/ex_pipeline_tb.sv
`timescale 1ns/1ps

module ex_pipeline_tb;

    // Stimulus cycles of all tests, bubbles included
    localparam int instr_count = 110;

    logic                ui_clk_from_ddr;
    logic                reset;
    logic                ex_valid;
    ex_pkg::alu_op_t     alu_op;
    ex_pkg::shift_op_t   shift_op;
    ex_pkg::exres_sel_t  exres_sel;
    logic                b_imm_sel;
    logic                shamt_sel;
    ex_pkg::shamt_t      shamt;
    ex_pkg::word_t       imm;
    ex_pkg::reg_addr_t   rs_addr;
    ex_pkg::reg_addr_t   rt_addr;
    ex_pkg::word_t       rs_data;
    ex_pkg::word_t       rt_data;
    ex_pkg::reg_addr_t   rd_addr;
    logic                reg_w;
    logic                of_trap;
    logic                wb_valid;
    logic                wb_reg_w;
    logic                wb_overflow;
    ex_pkg::reg_addr_t   wb_rd_addr;
    ex_pkg::word_t       wb_data;

    logic [31:0] rng_state = 32'he7eecc46;
    string       cur_test  = "init";
    logic        hold_reset;
    logic        rst_m;

    // Model of the EX result, MEM stage and WB stage
    logic e_valid, e_w, e_ovf, m_valid, m_w, m_ovf, w_valid, w_w, w_ovf;
    logic [4:0]  e_rd, m_rd, w_rd;
    logic [31:0] e_data, m_data, w_data;

    tb_clock u_clock (.clk(ui_clk_from_ddr));

    ex_pipeline u_dut (.*);

    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Register value as the pipeline would forward it
    function automatic logic [31:0] fwd_value(input logic [4:0] addr, input logic [31:0] data);
        if (addr != 0 && m_w && addr == m_rd)
            return m_data;
        if (addr != 0 && w_w && addr == w_rd)
            return w_data;
        return data;
    endfunction

    function automatic logic [32:0] alu_ref(input ex_pkg::alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [32:0] wide;
        wide = 33'd0;
        case (op)
            ex_pkg::alu_add:  wide = {a[31], a} + {b[31], b};
            ex_pkg::alu_sub:  wide = {a[31], a} - {b[31], b};
            ex_pkg::alu_addu: wide = {1'b0, a + b};
            ex_pkg::alu_subu: wide = {1'b0, a - b};
            ex_pkg::alu_and:  wide = {1'b0, a & b};
            ex_pkg::alu_or:   wide = {1'b0, a | b};
            ex_pkg::alu_xor:  wide = {1'b0, a ^ b};
            ex_pkg::alu_nor:  wide = {1'b0, ~(a | b)};
            ex_pkg::alu_slt:  wide = {32'd0, $signed(a) < $signed(b)};
            ex_pkg::alu_sltu: wide = {32'd0, a < b};
            ex_pkg::alu_lui:  wide = {1'b0, b[15:0], 16'h0000};
            default:          wide = 33'd0;
        endcase
        // Bit 32 flags signed overflow when the sign extension disagrees with bit 31
        if (op == ex_pkg::alu_add || op == ex_pkg::alu_sub)
            wide[32] = wide[32] ^ wide[31];
        return wide;
    endfunction

    function automatic logic [31:0] shift_ref(input ex_pkg::shift_op_t op, input logic [31:0] x,
                                              input logic [4:0] n);
        case (op)
            ex_pkg::shift_sll: return x << n;
            ex_pkg::shift_srl: return x >> n;
            ex_pkg::shift_sra: return $signed(x) >>> n;
            default:           return x;
        endcase
    endfunction

    // Per clock the model advances, the next instruction is driven and WB is compared
    task automatic step(input logic v, input ex_pkg::alu_op_t aop, input ex_pkg::shift_op_t sop,
                        input ex_pkg::exres_sel_t sel, input logic bimm, input logic ssel,
                        input logic [4:0] sa, input logic [31:0] im, input logic [4:0] rs,
                        input logic [4:0] rt, input logic [31:0] rsd, input logic [31:0] rtd,
                        input logic [4:0] rd, input logic w, input logic trap);
        logic [31:0] fa;
        logic [31:0] fb;
        logic [32:0] ar;
        @(posedge ui_clk_from_ddr);
        if (rst_m) begin
            {w_valid, w_w, w_ovf, w_rd, w_data} = '0;
            {m_valid, m_w, m_ovf, m_rd, m_data} = '0;
        end else begin
            {w_valid, w_w, w_ovf, w_rd, w_data} = {m_valid, m_w, m_ovf, m_rd, m_data};
            {m_valid, m_w, m_ovf} = {e_valid, e_w, e_ovf};
            if (e_valid) begin
                m_rd   = e_rd;
                m_data = e_data;
            end
        end
        reset     <= hold_reset;
        rst_m      = hold_reset;
        ex_valid  <= v;
        alu_op    <= aop;
        shift_op  <= sop;
        exres_sel <= sel;
        b_imm_sel <= bimm;
        shamt_sel <= ssel;
        shamt     <= sa;
        imm       <= im;
        rs_addr   <= rs;
        rt_addr   <= rt;
        rs_data   <= rsd;
        rt_data   <= rtd;
        rd_addr   <= rd;
        reg_w     <= w;
        of_trap   <= trap;
        fa = fwd_value(rs, rsd);
        fb = fwd_value(rt, rtd);
        ar = alu_ref(aop, fa, bimm ? im : fb);
        e_valid = v;
        e_rd    = rd;
        e_ovf   = v && sel == ex_pkg::res_alu && ar[32];
        e_w     = v && w && !(trap && e_ovf);
        case (sel)
            ex_pkg::res_shift:  e_data = shift_ref(sop, fb, ssel ? fa[4:0] : sa);
            ex_pkg::res_pass_a: e_data = fa;
            default:            e_data = ar[31:0];
        endcase
        @(negedge ui_clk_from_ddr);
        check("wb_valid", w_valid, wb_valid);
        check("wb_reg_w", w_w, wb_reg_w);
        check("wb_overflow", w_ovf, wb_overflow);
        if (w_valid) begin
            check("wb_rd_addr", w_rd, wb_rd_addr);
            check("wb_data", w_data, wb_data);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            step(0, ex_pkg::alu_add, ex_pkg::shift_sll, ex_pkg::res_alu, 0, 0, 0, 0,
                 0, 0, 0, 0, 0, 0, 0);
        end
    endtask

    // Plain register op with random rs and rt data
    task automatic alu_instr(input ex_pkg::alu_op_t op, input logic [4:0] rs, input logic [4:0] rt,
                             input logic [31:0] rsd, input logic [4:0] rd, input logic trap);
        step(1, op, ex_pkg::shift_sll, ex_pkg::res_alu, 0, 0, 0, 0, rs, rt, rsd,
             rand_word(), rd, 1, trap);
    endtask

    task automatic alu_ops();
        cur_test = "alu_ops";
        for (int i = 0; i <= 10; i++) begin
            alu_instr(ex_pkg::alu_op_t'(i), 2, 3, rand_word(), 4, 0);
            idle(3);
        end
    endtask

    task automatic shift_ops();
        logic [31:0] x;
        cur_test = "shifts";
        for (int s = 0; s < 3; s++) begin
            for (int v = 0; v < 2; v++) begin
                // Odd rounds take a negative input for the sign fill
                x = v ? (rand_word() | 32'h8000_0000) : rand_word();
                step(1, ex_pkg::alu_add, ex_pkg::shift_op_t'(s), ex_pkg::res_shift, 0, v[0],
                     5'(rand_word()), 0, 2, 3, rand_word(), x, 4, 1, 0);
                idle(2);
            end
        end
    endtask

    task automatic immediate_operand();
        cur_test = "immediate";
        step(1, ex_pkg::alu_addu, ex_pkg::shift_sll, ex_pkg::res_alu, 1, 0, 0, rand_word(),
             2, 3, rand_word(), rand_word(), 5, 1, 0);
        idle(2);
        step(1, ex_pkg::alu_lui, ex_pkg::shift_sll, ex_pkg::res_alu, 1, 0, 0, rand_word(),
             2, 3, rand_word(), rand_word(), 5, 1, 0);
        idle(2);
    endtask

    task automatic forwarding_paths();
        cur_test = "forward_mem";
        alu_instr(ex_pkg::alu_addu, 2, 3, rand_word(), 5, 0);
        alu_instr(ex_pkg::alu_addu, 5, 5, 32'hdead_beef, 6, 0);
        idle(3);
        cur_test = "forward_wb";
        alu_instr(ex_pkg::alu_addu, 2, 3, rand_word(), 7, 0);
        idle(1);
        alu_instr(ex_pkg::alu_or, 7, 3, 32'hbad0_bad0, 8, 0);
        idle(3);
        cur_test = "forward_priority";
        alu_instr(ex_pkg::alu_addu, 2, 3, rand_word(), 9, 0);
        alu_instr(ex_pkg::alu_subu, 2, 3, rand_word(), 9, 0);
        step(1, ex_pkg::alu_add, ex_pkg::shift_sll, ex_pkg::res_pass_a, 0, 0, 0, 0,
             9, 0, 32'h0bad_f00d, 0, 10, 1, 0);
        idle(3);
        cur_test = "forward_reg0";
        alu_instr(ex_pkg::alu_addu, 2, 3, rand_word(), 0, 0);
        alu_instr(ex_pkg::alu_addu, 0, 0, rand_word(), 11, 0);
        idle(3);
    endtask

    task automatic overflow_suppression();
        for (int t = 1; t >= 0; t--) begin
            if (t != 0) begin
                cur_test = "overflow_trap";
            end else begin
                cur_test = "overflow_no_trap";
            end
            step(1, ex_pkg::alu_add, ex_pkg::shift_sll, ex_pkg::res_alu, 0, 0, 0, 0,
                 8, 9, 32'h7fff_ffff, 32'h0000_0001, 10, 1, t[0]);
            alu_instr(ex_pkg::alu_addu, 10, 0, rand_word(), 11, 0);
            idle(3);
        end
    endtask

    task automatic reset_flush();
        cur_test = "reset_in_flight";
        alu_instr(ex_pkg::alu_addu, 2, 3, rand_word(), 12, 0);
        alu_instr(ex_pkg::alu_addu, 2, 3, rand_word(), 13, 0);
        hold_reset = 1'b1;
        alu_instr(ex_pkg::alu_addu, 2, 3, rand_word(), 14, 0);
        idle(1);
        hold_reset = 1'b0;
        idle(4);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        #((instr_count + 10) * 40);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Errors found");
        $fatal(1);
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        rst_m      = 1'b1;
        hold_reset = 1'b1;
        ex_valid   = 1'b0;
        alu_op     = ex_pkg::alu_add;
        shift_op   = ex_pkg::shift_sll;
        exres_sel  = ex_pkg::res_alu;
        b_imm_sel  = 1'b0;
        shamt_sel  = 1'b0;
        shamt      = '0;
        imm        = '0;
        rs_addr    = '0;
        rt_addr    = '0;
        rs_data    = '0;
        rt_data    = '0;
        rd_addr    = '0;
        reg_w      = 1'b0;
        of_trap    = 1'b0;
        {e_valid, e_w, e_ovf, e_rd, e_data} = '0;
        {m_valid, m_w, m_ovf, m_rd, m_data} = '0;
        {w_valid, w_w, w_ovf, w_rd, w_data} = '0;
        // Reset held over two edges
        idle(1);
        hold_reset = 1'b0;
        idle(1);
        alu_ops();
        shift_ops();
        immediate_operand();
        forwarding_paths();
        overflow_suppression();
        reset_flush();
        $display("No errors");
        $finish;
    end

endmodule

//--- sim/result_pipe_sva.sv
`timescale 1ns/1ps

module result_pipe_sva (
    input logic ui_clk_from_ddr,
    input logic reset,
    input logic ex_valid,
    input logic mem_valid,
    input logic wb_valid,
    input logic wb_reg_w
);

    // Fixed latency of two cycles
    assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        ex_valid |-> ##2 wb_valid)
        else $error("strobe did not reach the WB stage after two cycles");

    assert property (@(posedge ui_clk_from_ddr) wb_reg_w |-> wb_valid)
        else $error("WB write enable without a valid instruction");

    // Both stages empty right after reset
    assert property (@(posedge ui_clk_from_ddr) reset |=> (!mem_valid && !wb_valid))
        else $error("valid flag set in the cycle after reset");

endmodule

bind result_pipe result_pipe_sva u_result_pipe_sva (
    .ui_clk_from_ddr (ui_clk_from_ddr),
    .reset           (reset),
    .ex_valid        (ex_valid),
    .mem_valid       (mem_valid),
    .wb_valid        (wb_valid),
    .wb_reg_w        (wb_reg_w)
);

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule
